//--- hw/cp15Pkg.sv
package cp15Pkg;

  // ******************************************************************
  // Widths with a meaning
  // ******************************************************************

  typedef logic [31:0] cp15Word_t;
  typedef logic [3:0]  cp15Addr_t;
  typedef logic [2:0]  cp15Op2_t;
  typedef logic [3:0]  cp15Crm_t;

  // ******************************************************************
  // Bundles passed between the blocks
  // ******************************************************************

  // One access after arbitration between the CPU and MMU ports
  typedef struct packed {
    logic      write;
    logic      read;
    cp15Addr_t addr;
    cp15Word_t wdata;
    logic      fromMmu;
  } cp15Req_t;

  // Cache and TLB maintenance commands
  typedef struct packed {
    logic flushI;
    logic flushD;
    logic cleanI;
    logic cleanD;
    logic tlbFlushI;
    logic tlbFlushD;
  } cp15Maint_t;

  // Named enable bits of the control register
  typedef struct packed {
    logic highVectors;
    logic icacheEnable;
    logic dcacheEnable;
    logic alignCheck;
    logic mmuEnable;
  } cp15Ctrl_t;

  // ******************************************************************
  // Register map
  // ******************************************************************

  localparam cp15Addr_t REG_ID        = 4'd0;
  localparam cp15Addr_t REG_CONTROL   = 4'd1;
  localparam cp15Addr_t REG_TBASE     = 4'd2;
  localparam cp15Addr_t REG_CACHE_OPS = 4'd7;
  localparam cp15Addr_t REG_TLB_OPS   = 4'd8;

  // Bit positions inside register 1
  localparam int CTRL_BIT_MMU    = 0;
  localparam int CTRL_BIT_ALIGN  = 1;
  localparam int CTRL_BIT_DCACHE = 2;
  localparam int CTRL_BIT_ICACHE = 12;
  localparam int CTRL_BIT_HIVEC  = 13;

endpackage

//--- hw/cp15AccessArbiter.sv
module cp15AccessArbiter
  import cp15Pkg::*;
(
  input  logic      cpuWriteEn,
  input  logic      cpuEn,
  input  logic      mmuWriteEn,
  input  logic      mmuEn,
  input  cp15Word_t cpuWriteData,
  input  cp15Word_t mmuWriteData,
  input  cp15Addr_t addr,
  output cp15Req_t  req,
  output logic      stall
);

  // ******************************************************************
  // Read and write intents per port
  // ******************************************************************

  logic cpuRead;
  logic mmuRead;
  logic writeConflict;
  logic readConflict;
  logic anyWrite;
  logic anyRead;

  // Enable without write enable is a read (MRC on the CPU side)
  assign cpuRead = cpuEn & ~cpuWriteEn;
  assign mmuRead = mmuEn & ~mmuWriteEn;

  assign anyWrite = cpuWriteEn | mmuWriteEn;
  assign anyRead  = cpuRead | mmuRead;

  // ******************************************************************
  // Conflicts
  // ******************************************************************

  // Same kind of access from both masters in one cycle
  assign writeConflict = cpuWriteEn & mmuWriteEn;
  assign readConflict  = cpuRead & mmuRead;

  // CPU has to hold its request until this drops
  assign stall = writeConflict | readConflict;

  // ******************************************************************
  // Granted request
  // ******************************************************************

  always_comb begin
    req.write = anyWrite;
    req.read  = anyRead;
    req.addr  = addr;

    // MMU data wins when both write
    if (mmuWriteEn) begin
      req.wdata = mmuWriteData;
    end else begin
      req.wdata = cpuWriteData;
    end

    // Source of the write if there is one, else of the read
    if (anyWrite) begin
      req.fromMmu = mmuWriteEn;
    end else begin
      req.fromMmu = mmuRead;
    end
  end

endmodule

//--- hw/cp15RegFile.sv
module cp15RegFile
  import cp15Pkg::*;
#(
  parameter cp15Word_t idCode       = 32'h41069265,
  parameter cp15Word_t controlReset = 32'h0
) (
  input  logic      clk,
  input  logic      reset,
  input  cp15Req_t  req,
  output cp15Word_t rd,
  output cp15Word_t control,
  output cp15Word_t tbase
);

  // ******************************************************************
  // Storage
  // ******************************************************************

  // Register 0 is the ID constant, so only 1 to 15 are flops
  cp15Word_t regs    [1:15];
  cp15Word_t regView [0:15];
  logic      wrValid;

  // Writes to the ID register are dropped
  assign wrValid = req.write & (req.addr != REG_ID);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 16; i++) begin
        regs[i] <= '0;
      end
      regs[REG_CONTROL] <= controlReset;
    end else begin
      for (int i = 1; i < 16; i++) begin
        if (wrValid && (req.addr == cp15Addr_t'(i))) begin
          regs[i] <= req.wdata;
        end
      end
    end
  end

  // ******************************************************************
  // Read port
  // ******************************************************************

  // Full sixteen-entry view with the ID word in slot 0
  always_comb begin
    regView[0] = idCode;
    for (int i = 1; i < 16; i++) begin
      regView[i] = regs[i];
    end
  end

  // Bus idles at zero outside a read
  always_comb begin
    if (req.read) begin
      rd = regView[req.addr];
    end else begin
      rd = '0;
    end
  end

  // ******************************************************************
  // Always-visible registers
  // ******************************************************************

  // The MMU and the caches watch these continuously
  assign control = regs[REG_CONTROL];
  assign tbase   = regs[REG_TBASE];

endmodule

//--- hw/cp15MaintDecoder.sv
module cp15MaintDecoder
  import cp15Pkg::*;
(
  input  cp15Req_t   req,
  input  cp15Op2_t   opcode2,
  input  cp15Crm_t   crm,
  output cp15Maint_t maintNext
);

  // ******************************************************************
  // Qualifiers
  // ******************************************************************

  logic op2Valid;
  logic cacheWrite;
  logic tlbWrite;

  // Only opcode2 of 0 or 1 selects a maintenance operation
  assign op2Valid = (opcode2 == 3'd0) | (opcode2 == 3'd1);

  assign cacheWrite = req.write & op2Valid & (req.addr == REG_CACHE_OPS);
  assign tlbWrite   = req.write & op2Valid & (req.addr == REG_TLB_OPS);

  // ******************************************************************
  // Register 7, cache flush and clean
  // ******************************************************************

  always_comb begin
    {maintNext.flushI, maintNext.flushD, maintNext.cleanI, maintNext.cleanD} = 4'b0000;
    if (cacheWrite) begin
      case (crm)
        4'b0111: begin
          {maintNext.flushI, maintNext.flushD, maintNext.cleanI, maintNext.cleanD} = 4'b1100;
        end
        4'b0101: begin
          {maintNext.flushI, maintNext.flushD, maintNext.cleanI, maintNext.cleanD} = 4'b1000;
        end
        4'b0110: begin
          {maintNext.flushI, maintNext.flushD, maintNext.cleanI, maintNext.cleanD} = 4'b0100;
        end
        4'b1011: begin
          {maintNext.flushI, maintNext.flushD, maintNext.cleanI, maintNext.cleanD} = 4'b0011;
        end
        4'b1010: begin
          {maintNext.flushI, maintNext.flushD, maintNext.cleanI, maintNext.cleanD} = 4'b0001;
        end
        // Clean and flush both caches
        4'b1111: begin
          {maintNext.flushI, maintNext.flushD, maintNext.cleanI, maintNext.cleanD} = 4'b1111;
        end
        4'b1110: begin
          {maintNext.flushI, maintNext.flushD, maintNext.cleanI, maintNext.cleanD} = 4'b0101;
        end
        default: ;
      endcase
    end
  end

  // ******************************************************************
  // Register 8, TLB flush
  // ******************************************************************

  always_comb begin
    {maintNext.tlbFlushI, maintNext.tlbFlushD} = 2'b00;
    if (tlbWrite) begin
      case (crm)
        4'b0111: {maintNext.tlbFlushI, maintNext.tlbFlushD} = 2'b11;
        4'b0101: {maintNext.tlbFlushI, maintNext.tlbFlushD} = 2'b10;
        4'b0110: {maintNext.tlbFlushI, maintNext.tlbFlushD} = 2'b01;
        default: ;
      endcase
    end
  end

endmodule

//--- hw/cp15SysOutputs.sv
module cp15SysOutputs
  import cp15Pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  cp15Maint_t maintNext,
  input  cp15Word_t  control,
  output cp15Maint_t maint,
  output cp15Ctrl_t  ctrlFields
);

  // ******************************************************************
  // Maintenance pulses
  // ******************************************************************

  // One flop stage so each command starts cleanly at a clock edge,
  // the cycle after the write is taken
  always_ff @(posedge clk) begin
    if (reset) begin
      maint <= '0;
    end else begin
      maint <= maintNext;
    end
  end

  // ******************************************************************
  // Control register fields
  // ******************************************************************

  // M bit, turns address translation on
  assign ctrlFields.mmuEnable    = control[CTRL_BIT_MMU];

  // A bit
  assign ctrlFields.alignCheck   = control[CTRL_BIT_ALIGN];

  // C bit, data side cache
  assign ctrlFields.dcacheEnable = control[CTRL_BIT_DCACHE];

  // I bit, instruction side cache
  assign ctrlFields.icacheEnable = control[CTRL_BIT_ICACHE];

  // V bit, exception vectors at the top of memory
  assign ctrlFields.highVectors  = control[CTRL_BIT_HIVEC];

endmodule

//--- hw/coprocessor15.sv
module coprocessor15
  import cp15Pkg::*;
#(
  parameter cp15Word_t idCode       = 32'h41069265,
  parameter cp15Word_t controlReset = 32'h0
) (
  input  logic       clk,
  input  logic       reset,
  // Enable without write enable means read, on both ports
  input  logic       cpuWriteEn,
  input  logic       cpuEn,
  input  logic       mmuWriteEn,
  input  logic       mmuEn,
  input  cp15Word_t  cpuWriteData,
  input  cp15Word_t  mmuWriteData,
  input  cp15Addr_t  addr,
  input  cp15Op2_t   opcode2,
  input  cp15Crm_t   crm,
  output logic       stall,
  output cp15Word_t  rd,
  output cp15Word_t  control,
  output cp15Word_t  tbase,
  output cp15Maint_t maint,
  output cp15Ctrl_t  ctrlFields
);

  cp15Req_t   req;
  cp15Maint_t maintNext;

  cp15AccessArbiter arbiter_inst (
    .cpuWriteEn   (cpuWriteEn),
    .cpuEn        (cpuEn),
    .mmuWriteEn   (mmuWriteEn),
    .mmuEn        (mmuEn),
    .cpuWriteData (cpuWriteData),
    .mmuWriteData (mmuWriteData),
    .addr         (addr),
    .req          (req),
    .stall        (stall)
  );

  cp15RegFile #(
    .idCode       (idCode),
    .controlReset (controlReset)
  ) regFile_inst (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .rd      (rd),
    .control (control),
    .tbase   (tbase)
  );

  cp15MaintDecoder maintDecoder_inst (
    .req       (req),
    .opcode2   (opcode2),
    .crm       (crm),
    .maintNext (maintNext)
  );

  cp15SysOutputs sysOutputs_inst (
    .clk        (clk),
    .reset      (reset),
    .maintNext  (maintNext),
    .control    (control),
    .maint      (maint),
    .ctrlFields (ctrlFields)
  );

endmodule

//--- bench/coprocessor15Tb.sv
module coprocessor15Tb
  import cp15Pkg::*;
();

  localparam cp15Word_t ID_CODE       = 32'h4106_9265;
  localparam cp15Word_t CONTROL_RESET = 32'h0000_2005;
  localparam int        STALL_TIMEOUT = 8;

  logic       clk;
  logic       reset;
  logic       cpuWriteEn;
  logic       cpuEn;
  logic       mmuWriteEn;
  logic       mmuEn;
  cp15Word_t  cpuWriteData;
  cp15Word_t  mmuWriteData;
  cp15Addr_t  addr;
  cp15Op2_t   opcode2;
  cp15Crm_t   crm;
  logic       stall;
  cp15Word_t  rd;
  cp15Word_t  control;
  cp15Word_t  tbase;
  cp15Maint_t maint;
  cp15Ctrl_t  ctrlFields;

  logic [31:0] lfsrState;

  coprocessor15 #(
    .idCode       (ID_CODE),
    .controlReset (CONTROL_RESET)
  ) coprocessor15_inst (
    .clk          (clk),
    .reset        (reset),
    .cpuWriteEn   (cpuWriteEn),
    .cpuEn        (cpuEn),
    .mmuWriteEn   (mmuWriteEn),
    .mmuEn        (mmuEn),
    .cpuWriteData (cpuWriteData),
    .mmuWriteData (mmuWriteData),
    .addr         (addr),
    .opcode2      (opcode2),
    .crm          (crm),
    .stall        (stall),
    .rd           (rd),
    .control      (control),
    .tbase        (tbase),
    .maint        (maint),
    .ctrlFields   (ctrlFields)
  );

  always #2 clk = ~clk;

  // ******************************************************************
  // Reference model
  // ******************************************************************

  cp15Word_t  model [0:15];
  cp15Maint_t expMaint;
  logic       expWrite;
  logic       expRead;
  logic       expStall;
  cp15Word_t  expWdata;
  cp15Word_t  expRd;
  cp15Ctrl_t  expCtrl;

  assign expWrite = cpuWriteEn | mmuWriteEn;
  assign expRead  = (cpuEn & ~cpuWriteEn) | (mmuEn & ~mmuWriteEn);
  assign expStall = (cpuWriteEn & mmuWriteEn) | ((cpuEn & ~cpuWriteEn) & (mmuEn & ~mmuWriteEn));
  assign expWdata = mmuWriteEn ? mmuWriteData : cpuWriteData;
  assign expRd    = expRead ? model[addr] : 32'h0;
  // V, I, C, A and M bits of register 1
  assign expCtrl  = {model[1][13], model[1][12], model[1][2], model[1][1], model[1][0]};

  // Cache and TLB command tables for opcode2 of 0 or 1
  function automatic cp15Maint_t expectedMaint(input logic wr, input cp15Addr_t a,
                                               input cp15Op2_t op2, input cp15Crm_t c);
    cp15Maint_t m;
    m = '0;
    if (wr && (op2 <= 3'd1) && (a == 4'd7)) begin
      case (c)
        4'b0111: m = 6'b110000;
        4'b0101: m = 6'b100000;
        4'b0110: m = 6'b010000;
        4'b1011: m = 6'b001100;
        4'b1010: m = 6'b000100;
        4'b1111: m = 6'b111100;
        4'b1110: m = 6'b010100;
        default: m = '0;
      endcase
    end else if (wr && (op2 <= 3'd1) && (a == 4'd8)) begin
      case (c)
        4'b0111: m = 6'b000011;
        4'b0101: m = 6'b000010;
        4'b0110: m = 6'b000001;
        default: m = '0;
      endcase
    end
    return m;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) begin
        model[i] <= 32'h0;
      end
      model[0] <= ID_CODE;
      model[1] <= CONTROL_RESET;
      expMaint <= '0;
    end else begin
      // Register 0 is read-only
      if (expWrite && (addr != 4'd0)) begin
        model[addr] <= expWdata;
      end
      expMaint <= expectedMaint(expWrite, addr, opcode2, crm);
    end
  end

  // ******************************************************************
  // Checks
  // ******************************************************************

  task automatic stopOnError(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string name, input cp15Word_t got, input cp15Word_t exp);
    stopOnError($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
  endtask

  stallMatches: assert property (@(posedge clk) disable iff (reset) stall == expStall)
    else reportMismatch("stall", 32'($sampled(stall)), 32'($sampled(expStall)));
  rdMatches: assert property (@(posedge clk) disable iff (reset) rd == expRd)
    else reportMismatch("rd", $sampled(rd), $sampled(expRd));
  controlMatches: assert property (@(posedge clk) disable iff (reset) control == model[1])
    else reportMismatch("control", $sampled(control), $sampled(model[1]));
  tbaseMatches: assert property (@(posedge clk) disable iff (reset) tbase == model[2])
    else reportMismatch("tbase", $sampled(tbase), $sampled(model[2]));
  maintMatches: assert property (@(posedge clk) disable iff (reset) maint == expMaint)
    else reportMismatch("maint", 32'($sampled(maint)), 32'($sampled(expMaint)));
  ctrlFieldsMatch: assert property (@(posedge clk) disable iff (reset) ctrlFields == expCtrl)
    else reportMismatch("ctrlFields", 32'($sampled(ctrlFields)), 32'($sampled(expCtrl)));

  // ******************************************************************
  // Stimulus
  // ******************************************************************

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic cp15Word_t randomBits(input int count);
    cp15Word_t value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  // Applies one cycle of inputs at the rising edge
  task automatic drive(input logic cw, input logic ce, input logic mw, input logic me,
                       input cp15Addr_t a, input cp15Word_t cd, input cp15Word_t md,
                       input cp15Op2_t op2, input cp15Crm_t c);
    @(posedge clk);
    cpuWriteEn   <= cw;
    cpuEn        <= ce;
    mmuWriteEn   <= mw;
    mmuEn        <= me;
    addr         <= a;
    cpuWriteData <= cd;
    mmuWriteData <= md;
    opcode2      <= op2;
    crm          <= c;
  endtask

  task automatic idle();
    drive(1'b0, 1'b0, 1'b0, 1'b0, 4'd0, 32'h0, 32'h0, 3'd0, 4'd0);
  endtask

  task automatic readAll();
    for (int i = 0; i < 16; i++) begin
      drive(1'b0, ~i[0], 1'b0, i[0], cp15Addr_t'(i), 32'h0, 32'h0, 3'd0, 4'd0);
    end
    idle();
  endtask

  // Collision where the MMU wins and the CPU holds until the stall drops
  task automatic collide(input logic isWrite, input cp15Addr_t a,
                         input cp15Word_t cd, input cp15Word_t md);
    int waited;
    drive(isWrite, 1'b1, isWrite, 1'b1, a, cd, md, 3'd2, 4'd0);
    // A finished MMU write is followed by an MMU read of the same register
    drive(isWrite, 1'b1, 1'b0, isWrite, a, cd, md, 3'd2, 4'd0);
    waited = 0;
    @(negedge clk);
    while (stall) begin
      if (waited == STALL_TIMEOUT) begin
        stopOnError("CPU request still stalled after the MMU released the port");
      end
      waited++;
      @(negedge clk);
    end
    idle();
  endtask

  initial begin
    cp15Addr_t a;
    cp15Word_t d;
    logic      useMmu;
    clk          = 1'b0;
    reset        = 1'b1;
    cpuWriteEn   = 1'b0;
    cpuEn        = 1'b0;
    mmuWriteEn   = 1'b0;
    mmuEn        = 1'b0;
    cpuWriteData = 32'h0;
    mmuWriteData = 32'h0;
    addr         = 4'd0;
    opcode2      = 3'd0;
    crm          = 4'd0;
    lfsrState    = 32'h0000_70a7;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    readAll();

    // Random writes through both ports to registers 1 to 15
    for (int n = 0; n < 40; n++) begin
      useMmu = randomBits(1) != 32'h0;
      a = cp15Addr_t'(randomBits(4));
      if (a == 4'd0) begin
        a = 4'd15;
      end
      d = randomBits(32);
      // The idle port carries other data so the granted word is visible
      drive(~useMmu, ~useMmu, useMmu, useMmu, a, d, ~d,
            cp15Op2_t'(randomBits(3)), cp15Crm_t'(randomBits(4)));
    end
    idle();
    readAll();

    // Register 0 ignores writes
    drive(1'b1, 1'b1, 1'b0, 1'b0, 4'd0, randomBits(32), 32'h0, 3'd0, 4'd0);
    drive(1'b0, 1'b1, 1'b0, 1'b0, 4'd0, 32'h0, 32'h0, 3'd0, 4'd0);
    idle();

    for (int n = 0; n < 6; n++) begin
      collide(1'b1, cp15Addr_t'(randomBits(4)), randomBits(32), randomBits(32));
      collide(1'b0, cp15Addr_t'(randomBits(4)), 32'h0, 32'h0);
    end
    readAll();

    // Every CRm and opcode2 on the cache and TLB registers
    for (int r = 7; r < 9; r++) begin
      for (int op = 0; op < 8; op++) begin
        for (int c = 0; c < 16; c++) begin
          drive(1'b1, 1'b1, 1'b0, 1'b0, cp15Addr_t'(r), randomBits(32), 32'h0,
                cp15Op2_t'(op), cp15Crm_t'(c));
          idle();
        end
      end
      // Reads with a valid code give no pulse
      drive(1'b0, 1'b1, 1'b0, 1'b0, cp15Addr_t'(r), 32'h0, 32'h0, 3'd0, 4'b0111);
      drive(1'b0, 1'b0, 1'b0, 1'b1, cp15Addr_t'(r), 32'h0, 32'h0, 3'd1, 4'b1111);
      idle();
    end

    // Back-to-back write gives a two-cycle pulse
    drive(1'b0, 1'b0, 1'b1, 1'b1, 4'd8, 32'h0, 32'h1, 3'd0, 4'b0111);
    drive(1'b0, 1'b0, 1'b1, 1'b1, 4'd8, 32'h0, 32'h2, 3'd0, 4'b0111);
    idle();

    for (int n = 0; n < 12; n++) begin
      drive(1'b1, 1'b1, 1'b0, 1'b0, 4'd1, randomBits(32), 32'h0, 3'd0, 4'd0);
      idle();
    end

    repeat (4) idle();
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- src.f
hw/cp15Pkg.sv
hw/cp15AccessArbiter.sv
hw/cp15RegFile.sv
hw/cp15MaintDecoder.sv
hw/cp15SysOutputs.sv
hw/coprocessor15.sv
bench/coprocessor15Tb.sv

//--- Makefile
# Verilator build and run of the CP15 testbench

VERILATOR ?= verilator
TOP       ?= coprocessor15Tb
FILELIST  ?= src.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

# Sources as listed in the file list, header directories dropped
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# A $$fatal in the testbench gives a nonzero exit status
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)
